// File: testchip_params.svh
`ifndef TESTCHIP_PARAMS_SVH
`define TESTCHIP_PARAMS_SVH

// request and memory widths
`define TC_ADDR_W      8
`define TC_WORD_W      32
// one mask bit per byte lane
`define TC_MASK_W      4

// sram depths, chip 0 and chip 1
`define TC_DEPTH0      256
`define TC_DEPTH1      64
`define TC_NCHIPS      2

// chain length and field positions, msb first
`define TC_CHAIN_W     120
`define TC_SEL_BIT     119
`define TC_CSB0_BIT    118
`define TC_WEB0_BIT    117
`define TC_WMASK0_LSB  113
`define TC_ADDR0_LSB   105
`define TC_DIN0_LSB    73
`define TC_CSB1_BIT    72
`define TC_ADDR1_LSB   64
`define TC_DOUT0_LSB   32
`define TC_DOUT1_LSB   0

`endif

// File: sram_pkg.sv
`default_nettype none

`include "testchip_params.svh"

package sram_pkg;

   // one data word of either macro
   typedef logic [`TC_WORD_W-1:0] word_t;

   // request address, wide enough for the deepest macro
   typedef logic [`TC_ADDR_W-1:0] addr_t;

   // byte enables for port 0 writes
   typedef logic [`TC_MASK_W-1:0] wmask_t;

endpackage

`default_nettype wire

// File: scan_pkg.sv
`default_nettype none

`include "testchip_params.svh"

package scan_pkg;

   // full serial chain, request plus captured read data
   typedef logic [`TC_CHAIN_W-1:0] chain_t;

   // index of the target sram
   typedef logic [$clog2(`TC_NCHIPS)-1:0] chip_sel_t;

   // load sequencer
   // access drives the macro, wait lets dout settle into hold regs,
   // capture copies hold regs back into the chain
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_ACCESS  = 2'd1,
      ST_WAIT    = 2'd2,
      ST_CAPTURE = 2'd3
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: sram_1rw1r.sv
`default_nettype none
`timescale 1ns/1ns

`include "testchip_params.svh"

module sram_1rw1r #(
   parameter int DEPTH = 256
) (
   input  wire             clk,
   input  wire             csb0_i,
   input  wire             web0_i,
   input  wire sram_pkg::wmask_t wmask0_i,
   input  wire sram_pkg::addr_t  addr0_i,
   input  wire sram_pkg::word_t  din0_i,
   input  wire             csb1_i,
   input  wire sram_pkg::addr_t  addr1_i,
   output sram_pkg::word_t dout0_o,
   output sram_pkg::word_t dout1_o
);
   import sram_pkg::*;

   localparam int AW     = $clog2(DEPTH);
   localparam int BYTE_W = `TC_WORD_W / `TC_MASK_W;

   word_t         mem [DEPTH];
   logic [AW-1:0] a0;
   logic [AW-1:0] a1;

   // upper request address bits are ignored on the smaller macro
   assign a0 = addr0_i[AW-1:0];
   assign a1 = addr1_i[AW-1:0];

   // port 0, read/write
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            // masked write, dout0 holds its old value
            for (int b = 0; b < `TC_MASK_W; b++) begin
               if (wmask0_i[b]) begin
                  mem[a0][b*BYTE_W +: BYTE_W] <= din0_i[b*BYTE_W +: BYTE_W];
               end
            end
         end else begin
            dout0_o <= mem[a0];
         end
      end
   end

   // port 1, read only
   // disabled port keeps last word
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[a1];
      end
   end

endmodule

`default_nettype wire

// File: scan_chain.sv
`default_nettype none
`timescale 1ns/1ns

`include "testchip_params.svh"

module scan_chain (
   input  wire                   clk,
   input  wire                   rstn,
   input  wire                   scan_i,
   input  wire                   busy_i,
   input  wire                   gpio_i,
   input  wire                   cap_en_i,
   input  wire sram_pkg::word_t  hold0_i,
   input  wire sram_pkg::word_t  hold1_i,
   output logic                  gpio_o,
   output scan_pkg::chip_sel_t   sel_o,
   output logic                  csb0_o,
   output logic                  web0_o,
   output sram_pkg::wmask_t      wmask0_o,
   output sram_pkg::addr_t       addr0_o,
   output sram_pkg::word_t       din0_o,
   output logic                  csb1_o,
   output sram_pkg::addr_t       addr1_o
);
   import scan_pkg::*;

   chain_t chain_q;

   // capture has priority, shifting frozen while sequencer runs
   always_ff @(posedge clk) begin
      if (!rstn) begin
         chain_q <= '0;
      end else if (cap_en_i) begin
         // only the dout fields change, request bits stay put
         chain_q[`TC_DOUT0_LSB +: `TC_WORD_W] <= hold0_i;
         chain_q[`TC_DOUT1_LSB +: `TC_WORD_W] <= hold1_i;
      end else if (scan_i && !busy_i) begin
         // shift toward msb, new bit enters at 0
         chain_q <= {chain_q[`TC_CHAIN_W-2:0], gpio_i};
      end
   end

   // serial out straight from the msb flop
   assign gpio_o = chain_q[`TC_CHAIN_W-1];

   // request field decode
   assign sel_o    = chain_q[`TC_SEL_BIT];
   assign csb0_o   = chain_q[`TC_CSB0_BIT];
   assign web0_o   = chain_q[`TC_WEB0_BIT];
   assign wmask0_o = chain_q[`TC_WMASK0_LSB +: `TC_MASK_W];
   assign addr0_o  = chain_q[`TC_ADDR0_LSB +: `TC_ADDR_W];
   assign din0_o   = chain_q[`TC_DIN0_LSB +: `TC_WORD_W];
   assign csb1_o   = chain_q[`TC_CSB1_BIT];
   assign addr1_o  = chain_q[`TC_ADDR1_LSB +: `TC_ADDR_W];

endmodule

`default_nettype wire

// File: access_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

`include "testchip_params.svh"

module access_ctrl (
   input  wire                   clk,
   input  wire                   rstn,
   input  wire                   load_i,
   input  wire                   global_csb_i,
   input  wire scan_pkg::chip_sel_t sel_i,
   input  wire                   csb0_i,
   input  wire                   web0_i,
   input  wire sram_pkg::wmask_t wmask0_i,
   input  wire sram_pkg::addr_t  addr0_i,
   input  wire sram_pkg::word_t  din0_i,
   input  wire                   csb1_i,
   input  wire sram_pkg::addr_t  addr1_i,
   input  wire sram_pkg::word_t  dout0_i [`TC_NCHIPS],
   input  wire sram_pkg::word_t  dout1_i [`TC_NCHIPS],
   output logic                  busy_o,
   output logic                  cap_en_o,
   output sram_pkg::word_t       hold0_o,
   output sram_pkg::word_t       hold1_o,
   output logic [`TC_NCHIPS-1:0] csb0_o,
   output logic [`TC_NCHIPS-1:0] csb1_o,
   output logic [`TC_NCHIPS-1:0] web0_o,
   output sram_pkg::wmask_t      wmask0_o [`TC_NCHIPS],
   output sram_pkg::addr_t       addr0_o [`TC_NCHIPS],
   output sram_pkg::addr_t       addr1_o [`TC_NCHIPS],
   output sram_pkg::word_t       din0_o [`TC_NCHIPS]
);
   import sram_pkg::*;
   import scan_pkg::*;

   ctrl_state_t           state_q;
   chip_sel_t             sel_q;
   wmask_t                wmask0_q;
   addr_t                 addr0_q;
   addr_t                 addr1_q;
   word_t                 din0_q;
   logic                  start;
   logic [`TC_NCHIPS-1:0] chip_en;

   // E0, load seen while idle
   assign start = (state_q == ST_IDLE) && load_i;

   // also busy at E0 so a shift can't disturb the request
   assign busy_o   = start || (state_q != ST_IDLE);
   assign cap_en_o = (state_q == ST_CAPTURE);

   // chip decode under the global gate
   always_comb begin
      for (int i = 0; i < `TC_NCHIPS; i++) begin
         chip_en[i] = (sel_i == chip_sel_t'(i)) && !global_csb_i;
      end
   end

   // fixed walk, E0 -> access -> wait -> capture -> idle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q <= ST_IDLE;
      end else begin
         unique case (state_q)
            ST_IDLE:    if (load_i) state_q <= ST_ACCESS;
            ST_ACCESS:  state_q <= ST_WAIT;
            ST_WAIT:    state_q <= ST_CAPTURE;
            ST_CAPTURE: state_q <= ST_IDLE;
            default:    state_q <= ST_IDLE;
         endcase
      end
   end

   // request payload, taken at E0
   always_ff @(posedge clk) begin
      if (start) begin
         sel_q    <= sel_i;
         wmask0_q <= wmask0_i;
         addr0_q  <= addr0_i;
         addr1_q  <= addr1_i;
         din0_q   <= din0_i;
      end
   end

   // enables low for one cycle only, chosen chip only
   always_ff @(posedge clk) begin
      if (!rstn) begin
         csb0_o <= '1;
         csb1_o <= '1;
         web0_o <= '1;
      end else if (start) begin
         csb0_o <= ~(chip_en & {`TC_NCHIPS{!csb0_i}});
         csb1_o <= ~(chip_en & {`TC_NCHIPS{!csb1_i}});
         web0_o <= ~(chip_en & {`TC_NCHIPS{!web0_i}});
      end else begin
         csb0_o <= '1;
         csb1_o <= '1;
         web0_o <= '1;
      end
   end

   // E2, sram dout registered at E1 is stable now
   always_ff @(posedge clk) begin
      if (!rstn) begin
         hold0_o <= '0;
         hold1_o <= '0;
      end else if (state_q == ST_WAIT) begin
         hold0_o <= dout0_i[sel_q];
         hold1_o <= dout1_i[sel_q];
      end
   end

   // shared address and data fan out to every macro
   always_comb begin
      for (int i = 0; i < `TC_NCHIPS; i++) begin
         wmask0_o[i] = wmask0_q;
         addr0_o[i]  = addr0_q;
         addr1_o[i]  = addr1_q;
         din0_o[i]   = din0_q;
      end
   end

endmodule

`default_nettype wire

// File: testchip_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "testchip_params.svh"

module testchip_top (
   input  wire clk,
   input  wire rstn,
   input  wire scan_i,
   input  wire load_i,
   input  wire global_csb_i,
   input  wire gpio_i,
   output wire gpio_o
);
   import sram_pkg::*;
   import scan_pkg::*;

   // request decoded from the chain
   chip_sel_t req_sel;
   logic      req_csb0;
   logic      req_web0;
   wmask_t    req_wmask0;
   addr_t     req_addr0;
   word_t     req_din0;
   logic      req_csb1;
   addr_t     req_addr1;

   // sequencer back to chain
   logic      busy;
   logic      cap_en;
   word_t     hold0;
   word_t     hold1;

   // per macro ports
   logic [`TC_NCHIPS-1:0] csb0;
   logic [`TC_NCHIPS-1:0] csb1;
   logic [`TC_NCHIPS-1:0] web0;
   wmask_t                wmask0 [`TC_NCHIPS];
   addr_t                 addr0 [`TC_NCHIPS];
   addr_t                 addr1 [`TC_NCHIPS];
   word_t                 din0 [`TC_NCHIPS];
   word_t                 dout0 [`TC_NCHIPS];
   word_t                 dout1 [`TC_NCHIPS];

   scan_chain u_chain (
      .clk      (clk),
      .rstn     (rstn),
      .scan_i   (scan_i),
      .busy_i   (busy),
      .gpio_i   (gpio_i),
      .cap_en_i (cap_en),
      .hold0_i  (hold0),
      .hold1_i  (hold1),
      .gpio_o   (gpio_o),
      .sel_o    (req_sel),
      .csb0_o   (req_csb0),
      .web0_o   (req_web0),
      .wmask0_o (req_wmask0),
      .addr0_o  (req_addr0),
      .din0_o   (req_din0),
      .csb1_o   (req_csb1),
      .addr1_o  (req_addr1)
   );

   access_ctrl u_ctrl (
      .clk          (clk),
      .rstn         (rstn),
      .load_i       (load_i),
      .global_csb_i (global_csb_i),
      .sel_i        (req_sel),
      .csb0_i       (req_csb0),
      .web0_i       (req_web0),
      .wmask0_i     (req_wmask0),
      .addr0_i      (req_addr0),
      .din0_i       (req_din0),
      .csb1_i       (req_csb1),
      .addr1_i      (req_addr1),
      .dout0_i      (dout0),
      .dout1_i      (dout1),
      .busy_o       (busy),
      .cap_en_o     (cap_en),
      .hold0_o      (hold0),
      .hold1_o      (hold1),
      .csb0_o       (csb0),
      .csb1_o       (csb1),
      .web0_o       (web0),
      .wmask0_o     (wmask0),
      .addr0_o      (addr0),
      .addr1_o      (addr1),
      .din0_o       (din0)
   );

   // chip 0, 32x256
   sram_1rw1r #(.DEPTH(`TC_DEPTH0)) u_sram0 (
      .clk      (clk),
      .csb0_i   (csb0[0]),
      .web0_i   (web0[0]),
      .wmask0_i (wmask0[0]),
      .addr0_i  (addr0[0]),
      .din0_i   (din0[0]),
      .csb1_i   (csb1[0]),
      .addr1_i  (addr1[0]),
      .dout0_o  (dout0[0]),
      .dout1_o  (dout1[0])
   );

   // chip 1, 32x64
   sram_1rw1r #(.DEPTH(`TC_DEPTH1)) u_sram1 (
      .clk      (clk),
      .csb0_i   (csb0[1]),
      .web0_i   (web0[1]),
      .wmask0_i (wmask0[1]),
      .addr0_i  (addr0[1]),
      .din0_i   (din0[1]),
      .csb1_i   (csb1[1]),
      .addr1_i  (addr1[1]),
      .dout0_o  (dout0[1]),
      .dout1_o  (dout1[1])
   );

endmodule

`default_nettype wire

// File: tb_testchip.sv
`default_nettype none
`timescale 1ns/1ns

`include "testchip_params.svh"

module tb_testchip;
   import sram_pkg::*;
   import scan_pkg::*;

   // about 50 scans of ~126 cycles each make roughly 6500 cycles
   // limit gives about 3x margin
   localparam int MAX_CYCLES = 20000;

   logic clk = 1'b0;
   logic rstn;
   logic scan_i;
   logic load_i;
   logic global_csb_i;
   logic gpio_i;
   wire  gpio_o;

   // reference memories with a per word known flag
   // last dout per chip and port
   word_t ref_mem [`TC_NCHIPS][`TC_DEPTH0];
   bit    ref_ok  [`TC_NCHIPS][`TC_DEPTH0];
   word_t d0_ref  [`TC_NCHIPS];
   word_t d1_ref  [`TC_NCHIPS];
   bit    d0_ok   [`TC_NCHIPS];
   bit    d1_ok   [`TC_NCHIPS];

   // chain expected on the next scan
   // care mask drops unknown dout bits
   chain_t      exp_chain;
   chain_t      exp_care;
   logic [31:0] rng = 32'hde32_6953;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          failed_tests = 0;
   int          cycles = 0;

   testchip_top dut0 (
      .clk          (clk),
      .rstn         (rstn),
      .scan_i       (scan_i),
      .load_i       (load_i),
      .global_csb_i (global_csb_i),
      .gpio_i       (gpio_i),
      .gpio_o       (gpio_o)
   );

   always #50 clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run still going after %0d cycles", cycles);
         $display("Something failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // smaller macro only sees the low address bits
   function automatic int mem_index(input bit sel, input addr_t a);
      if (sel) begin
         return int'(a) % `TC_DEPTH1;
      end
      return int'(a) % `TC_DEPTH0;
   endfunction

   // din goes in msb first while the old chain comes out msb first
   task automatic scan_xfer(input chain_t din, output chain_t dout);
      for (int i = `TC_CHAIN_W-1; i >= 0; i--) begin
         @(posedge clk);
         scan_i <= 1'b1;
         gpio_i <= din[i];
         // msb before this shift
         @(negedge clk);
         dout[i] = gpio_o;
      end
      @(posedge clk);
      scan_i <= 1'b0;
   endtask

   // one load pulse followed by E0 through E3
   task automatic do_access(input bit gate);
      @(posedge clk);
      global_csb_i <= gate;
      load_i <= 1'b1;
      @(posedge clk);
      load_i <= 1'b0;
      repeat (3) @(posedge clk);
   endtask

   task automatic check_shift(input chain_t next);
      chain_t got;
      scan_xfer(next, got);
      checks++;
      if ((got & exp_care) !== (exp_chain & exp_care)) begin
         $display("CHECK FAILED at %0t ns: gpio_o chain expected %h got %h",
                  $time, exp_chain & exp_care, got & exp_care);
         errors++;
      end
   endtask

   task automatic update_model(input bit sel, input bit c0, input bit w0,
                               input wmask_t m, input addr_t a0, input word_t d,
                               input bit c1, input addr_t a1, input bit gate);
      int i0;
      int i1;
      i0 = mem_index(sel, a0);
      i1 = mem_index(sel, a1);
      // gated request touches neither memory nor dout
      if (!gate && !c1) begin
         d1_ref[sel] = ref_mem[sel][i1];
         d1_ok[sel]  = ref_ok[sel][i1];
      end
      if (!gate && !c0 && w0) begin
         d0_ref[sel] = ref_mem[sel][i0];
         d0_ok[sel]  = ref_ok[sel][i0];
      end
      if (!gate && !c0 && !w0) begin
         for (int b = 0; b < `TC_MASK_W; b++) begin
            if (m[b]) begin
               ref_mem[sel][i0][8*b +: 8] = d[8*b +: 8];
            end
         end
         // word fully known only after a full mask write
         if (m == 4'hf) begin
            ref_ok[sel][i0] = 1'b1;
         end
      end
   endtask

   // previous result comes out while this request goes in
   task automatic run_request(input bit sel, input bit c0, input bit w0,
                              input wmask_t m, input addr_t a0, input word_t d,
                              input bit c1, input addr_t a1, input bit gate);
      chain_t req;
      req = {sel, c0, w0, m, a0, d, c1, a1, 64'h0};
      check_shift(req);
      do_access(gate);
      update_model(sel, c0, w0, m, a0, d, c1, a1, gate);
      exp_chain = {req[119:64], d0_ref[sel], d1_ref[sel]};
      exp_care  = {{56{1'b1}}, {32{d0_ok[sel]}}, {32{d1_ok[sel]}}};
   endtask

   // pull the last result out and leave the chain all zero
   task automatic drain_chain();
      check_shift('0);
      exp_chain = '0;
      exp_care  = '1;
   endtask

   task automatic report_test(input string name, input int err_before);
      tests++;
      if (errors == err_before) begin
         $display("%s: pass", name);
      end else begin
         $display("%s: fail", name);
         failed_tests++;
      end
   endtask

   task automatic reset_values();
      int e;
      e = errors;
      exp_chain = '0;
      exp_care  = '1;
      drain_chain();
      report_test("reset", e);
   endtask

   task automatic full_write_read();
      int e;
      e = errors;
      run_request(1'b0, 1'b0, 1'b0, 4'hf, 8'h3c, 32'hcafe_f00d, 1'b1, 8'h00, 1'b0);
      run_request(1'b0, 1'b0, 1'b1, 4'h0, 8'h3c, 32'h0, 1'b1, 8'h00, 1'b0);
      drain_chain();
      report_test("full write and read", e);
   endtask

   task automatic byte_mask_write();
      int e;
      e = errors;
      run_request(1'b0, 1'b0, 1'b0, 4'hf, 8'h41, 32'h1122_3344, 1'b1, 8'h00, 1'b0);
      // only bytes 0 and 2 change
      run_request(1'b0, 1'b0, 1'b0, 4'b0101, 8'h41, 32'haabb_ccdd, 1'b1, 8'h00, 1'b0);
      run_request(1'b0, 1'b0, 1'b1, 4'h0, 8'h41, 32'h0, 1'b1, 8'h00, 1'b0);
      drain_chain();
      report_test("byte mask", e);
   endtask

   task automatic dual_port_access();
      int e;
      e = errors;
      run_request(1'b1, 1'b0, 1'b0, 4'hf, 8'h05, 32'h5151_0001, 1'b1, 8'h00, 1'b0);
      run_request(1'b0, 1'b0, 1'b0, 4'hf, 8'h05, 32'h0000_5005, 1'b1, 8'h00, 1'b0);
      // write 09 on port 0 and read 05 on port 1 in the same cycle
      run_request(1'b0, 1'b0, 1'b0, 4'hf, 8'h09, 32'h0909_0909, 1'b0, 8'h05, 1'b0);
      // chip 1 at 05 keeps its own word
      run_request(1'b1, 1'b1, 1'b1, 4'h0, 8'h00, 32'h0, 1'b0, 8'h05, 1'b0);
      // port 0 write from the shared access landed
      run_request(1'b0, 1'b0, 1'b1, 4'h0, 8'h09, 32'h0, 1'b1, 8'h00, 1'b0);
      drain_chain();
      report_test("dual port", e);
   endtask

   task automatic global_gate();
      int e;
      e = errors;
      run_request(1'b0, 1'b0, 1'b0, 4'hf, 8'h77, 32'h7777_0000, 1'b0, 8'h41, 1'b0);
      run_request(1'b0, 1'b0, 1'b0, 4'hf, 8'h77, 32'hdead_beef, 1'b0, 8'h3c, 1'b1);
      run_request(1'b0, 1'b0, 1'b1, 4'h0, 8'h77, 32'h0, 1'b0, 8'h77, 1'b0);
      drain_chain();
      report_test("global gate", e);
   endtask

   task automatic random_traffic();
      int          e;
      logic [31:0] r;
      word_t       d;
      bit          sel;
      bit          c0;
      bit          w0;
      bit          c1;
      bit          gate;
      wmask_t      m;
      addr_t       a0;
      addr_t       a1;
      e = errors;
      for (int n = 0; n < 30; n++) begin
         rng = xorshift(rng);
         r = rng;
         rng = xorshift(rng);
         d = rng;
         sel  = r[0];
         c0   = (r[3:1] == 3'd0);
         w0   = r[4];
         m    = r[8:5];
         // small address pool whose top bits alias on chip 1
         a0   = {r[10:9], 4'h0, r[12:11]};
         c1   = r[13];
         a1   = {r[15:14], 4'h0, r[17:16]};
         gate = (r[20:18] == 3'd0);
         if (!ref_ok[sel][mem_index(sel, a0)]) begin
            m = 4'hf;
         end
         // same word on both ports with a write is undefined
         if (!w0 && !c0 && !c1 && mem_index(sel, a1) == mem_index(sel, a0)) begin
            a1 = a1 ^ 8'h01;
         end
         run_request(sel, c0, w0, m, a0, d, c1, a1, gate);
      end
      drain_chain();
      report_test("random traffic", e);
   endtask

   initial begin
      rstn = 1'b0;
      scan_i = 1'b0;
      load_i = 1'b0;
      global_csb_i = 1'b0;
      gpio_i = 1'b0;
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      reset_values();
      full_write_read();
      byte_mask_write();
      dual_port_access();
      global_gate();
      random_traffic();
      $display("%0d tests, %0d failed, %0d checks, %0d check errors",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
sram_pkg.sv
scan_pkg.sv
sram_1rw1r.sv
scan_chain.sv
access_ctrl.sv
testchip_top.sv
tb_testchip.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_testchip -o tb_testchip
	./obj_dir/tb_testchip | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
